// ==== fft_pkg.sv ====
package fft_pkg;

	// transform size and the derived address and pair widths
	localparam int N_POINTS = 16;
	localparam int ADDR_W = 4;
	localparam int PAIR_W = 3;
	localparam int LEVEL_W = 2;

	// sample parts are plain two's complement, twiddles are Q2.14
	localparam int DATA_W = 16;
	localparam int TW_FRAC = 14;

	// one real or imaginary part of a sample
	typedef logic signed [DATA_W-1:0] sample_t;

	// a location in one bank of the sample memory
	typedef logic [ADDR_W-1:0] addr_t;

	// butterfly pair number, also used as the twiddle index
	typedef logic [PAIR_W-1:0] pair_t;

	// stage level, 0 is the first stage of the transform
	typedef logic [LEVEL_W-1:0] level_t;

	// the sequencer waits in drain until the last result pair is written
	typedef enum logic [1:0]
	{
		seq_idle = 2'd0,
		seq_run = 2'd1,
		seq_drain = 2'd2
	} seq_state_e;

endpackage

// ==== pair_sequencer.sv ====
`timescale 1ns/1ps

module pair_sequencer
(
	input logic clk,
	input logic reset,
	input logic start,
	input fft_pkg::level_t level,
	input logic done,
	output logic busy,
	output logic issue,
	output fft_pkg::addr_t rd_even_addr,
	output fft_pkg::addr_t rd_odd_addr,
	output fft_pkg::pair_t tw_index,
	output fft_pkg::addr_t issue_even_addr,
	output fft_pkg::addr_t issue_odd_addr,
	output logic issue_last
);

	fft_pkg::seq_state_e state, state_d;
	fft_pkg::pair_t pair_cnt, pair_cnt_d;
	fft_pkg::pair_t series_mask, series_mask_d;
	fft_pkg::addr_t span, span_d;
	fft_pkg::addr_t even_addr;
	fft_pkg::addr_t odd_addr;

	// low pair bits stay in place, the bits above the mask move up one
	// place so that the span bit of the even address is always zero
	assign even_addr = {1'b0, pair_cnt & series_mask} | ({1'b0, pair_cnt & ~series_mask} << 1);
	assign odd_addr = even_addr + span;

	assign issue = (state == fft_pkg::seq_run);
	assign busy = (state != fft_pkg::seq_idle);

	assign rd_even_addr = even_addr;
	assign rd_odd_addr = odd_addr;
	assign issue_even_addr = even_addr;
	assign issue_odd_addr = odd_addr;
	assign tw_index = pair_cnt & ~series_mask;
	assign issue_last = issue && (pair_cnt == fft_pkg::pair_t'('1));

	always_comb
	begin
		state_d = state;
		pair_cnt_d = pair_cnt;
		series_mask_d = series_mask;
		span_d = span;
		case (state)
			fft_pkg::seq_idle:
			begin
				// a start while busy never reaches this branch
				if (start)
				begin
					series_mask_d = fft_pkg::pair_t'('1) >> level;
					span_d = fft_pkg::addr_t'(fft_pkg::N_POINTS / 2) >> level;
					pair_cnt_d = '0;
					state_d = fft_pkg::seq_run;
				end
			end
			fft_pkg::seq_run:
			begin
				if (pair_cnt == fft_pkg::pair_t'('1))
				begin
					state_d = fft_pkg::seq_drain;
				end
				else
				begin
					pair_cnt_d = pair_cnt + 1'b1;
				end
			end
			fft_pkg::seq_drain:
			begin
				// the buffer flags done after the bank swap
				if (done)
				begin
					state_d = fft_pkg::seq_idle;
				end
			end
			default:
			begin
				state_d = fft_pkg::seq_idle;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= fft_pkg::seq_idle;
			pair_cnt <= '0;
			series_mask <= '0;
			span <= '0;
		end
		else
		begin
			state <= state_d;
			pair_cnt <= pair_cnt_d;
			series_mask <= series_mask_d;
			span <= span_d;
		end
	end

endmodule

// ==== sample_buffer.sv ====
`timescale 1ns/1ps

module sample_buffer
(
	input logic clk,
	input logic reset,
	input logic issue,
	input fft_pkg::addr_t rd_even_addr,
	input fft_pkg::addr_t rd_odd_addr,
	input logic res_valid,
	input logic res_last,
	input fft_pkg::addr_t res_even_addr,
	input fft_pkg::addr_t res_odd_addr,
	input fft_pkg::sample_t res_even_real,
	input fft_pkg::sample_t res_even_imag,
	input fft_pkg::sample_t res_odd_real,
	input fft_pkg::sample_t res_odd_imag,
	input logic load_en,
	input fft_pkg::addr_t load_addr,
	input fft_pkg::sample_t load_real,
	input fft_pkg::sample_t load_imag,
	input fft_pkg::addr_t rd_addr,
	output fft_pkg::sample_t even_real,
	output fft_pkg::sample_t even_imag,
	output fft_pkg::sample_t odd_real,
	output fft_pkg::sample_t odd_imag,
	output fft_pkg::sample_t rd_real,
	output fft_pkg::sample_t rd_imag,
	output logic done
);

	// a stage reads one bank and writes the other
	fft_pkg::sample_t bank_real [0:1][0:fft_pkg::N_POINTS-1];
	fft_pkg::sample_t bank_imag [0:1][0:fft_pkg::N_POINTS-1];

	logic src_bank;
	logic dst_bank;

	assign dst_bank = ~src_bank;

	// bank select and completion flag
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			src_bank <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			// results of the finished stage become the next source
			if (res_valid && res_last)
			begin
				src_bank <= ~src_bank;
			end
			done <= res_valid && res_last;
		end
	end

	// the pair for the butterfly is read one cycle after issue
	always_ff @(posedge clk)
	begin
		if (issue)
		begin
			even_real <= bank_real[src_bank][rd_even_addr];
			even_imag <= bank_imag[src_bank][rd_even_addr];
			odd_real <= bank_real[src_bank][rd_odd_addr];
			odd_imag <= bank_imag[src_bank][rd_odd_addr];
		end
	end

	// host read port always looks at the source bank
	always_ff @(posedge clk)
	begin
		rd_real <= bank_real[src_bank][rd_addr];
		rd_imag <= bank_imag[src_bank][rd_addr];
	end

	// host loads go to the source bank and results to the other one,
	// so the two never land in the same bank
	always_ff @(posedge clk)
	begin
		if (load_en)
		begin
			bank_real[src_bank][load_addr] <= load_real;
			bank_imag[src_bank][load_addr] <= load_imag;
		end
		if (res_valid)
		begin
			bank_real[dst_bank][res_even_addr] <= res_even_real;
			bank_imag[dst_bank][res_even_addr] <= res_even_imag;
			bank_real[dst_bank][res_odd_addr] <= res_odd_real;
			bank_imag[dst_bank][res_odd_addr] <= res_odd_imag;
		end
	end

endmodule

// ==== butterfly.sv ====
`timescale 1ns/1ps

module butterfly
(
	input logic clk,
	input logic reset,
	input logic issue,
	input fft_pkg::pair_t tw_index,
	input fft_pkg::addr_t issue_even_addr,
	input fft_pkg::addr_t issue_odd_addr,
	input logic issue_last,
	input fft_pkg::sample_t even_real,
	input fft_pkg::sample_t even_imag,
	input fft_pkg::sample_t odd_real,
	input fft_pkg::sample_t odd_imag,
	output logic res_valid,
	output logic res_last,
	output fft_pkg::addr_t res_even_addr,
	output fft_pkg::addr_t res_odd_addr,
	output fft_pkg::sample_t res_even_real,
	output fft_pkg::sample_t res_even_imag,
	output fft_pkg::sample_t res_odd_real,
	output fft_pkg::sample_t res_odd_imag
);

	// each word holds the real part in the upper half and the imaginary part below
	logic [2*fft_pkg::DATA_W-1:0] tw_rom [0:fft_pkg::N_POINTS/2-1];

	initial
	begin
		$readmemh("twiddle.hex", tw_rom);
	end

	// valid and last walk through the three stages together
	logic [2:0] valid_sr;
	logic [2:0] last_sr;

	fft_pkg::sample_t tw_real_s0, tw_imag_s0;
	fft_pkg::addr_t even_addr_s0, odd_addr_s0;
	fft_pkg::addr_t even_addr_s1, odd_addr_s1;
	fft_pkg::sample_t even_real_s1, even_imag_s1;
	fft_pkg::sample_t prod_real_s1, prod_imag_s1;

	logic signed [2*fft_pkg::DATA_W-1:0] pp_rr, pp_ii, pp_ri, pp_ir;
	logic signed [2*fft_pkg::DATA_W:0] prod_real_full, prod_imag_full;
	logic signed [2*fft_pkg::DATA_W:0] prod_real_sh, prod_imag_sh;

	// the odd sample arrives together with stage 0 and is multiplied by its twiddle
	assign pp_rr = odd_real * tw_real_s0;
	assign pp_ii = odd_imag * tw_imag_s0;
	assign pp_ri = odd_real * tw_imag_s0;
	assign pp_ir = odd_imag * tw_real_s0;
	assign prod_real_full = pp_rr - pp_ii;
	assign prod_imag_full = pp_ri + pp_ir;
	assign prod_real_sh = prod_real_full >>> fft_pkg::TW_FRAC;
	assign prod_imag_sh = prod_imag_full >>> fft_pkg::TW_FRAC;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			valid_sr <= '0;
			last_sr <= '0;
		end
		else
		begin
			valid_sr <= {valid_sr[1:0], issue};
			last_sr <= {last_sr[1:0], issue && issue_last};
		end
	end

	assign res_valid = valid_sr[2];
	assign res_last = last_sr[2];

	always_ff @(posedge clk)
	begin
		// stage 0 looks up the twiddle while the buffer reads the pair
		tw_real_s0 <= tw_rom[tw_index][2*fft_pkg::DATA_W-1:fft_pkg::DATA_W];
		tw_imag_s0 <= tw_rom[tw_index][fft_pkg::DATA_W-1:0];
		even_addr_s0 <= issue_even_addr;
		odd_addr_s0 <= issue_odd_addr;

		// stage 1 keeps only the low bits of the scaled product since the results wrap
		prod_real_s1 <= prod_real_sh[fft_pkg::DATA_W-1:0];
		prod_imag_s1 <= prod_imag_sh[fft_pkg::DATA_W-1:0];
		even_real_s1 <= even_real;
		even_imag_s1 <= even_imag;
		even_addr_s1 <= even_addr_s0;
		odd_addr_s1 <= odd_addr_s0;

		// stage 2 forms sum and difference
		res_even_real <= even_real_s1 + prod_real_s1;
		res_even_imag <= even_imag_s1 + prod_imag_s1;
		res_odd_real <= even_real_s1 - prod_real_s1;
		res_odd_imag <= even_imag_s1 - prod_imag_s1;
		res_even_addr <= even_addr_s1;
		res_odd_addr <= odd_addr_s1;
	end

endmodule

// ==== fft_stage_top.sv ====
`timescale 1ns/1ps

module fft_stage_top
(
	input logic clk,
	input logic reset,
	input logic start,
	input fft_pkg::level_t level,
	input logic load_en,
	input fft_pkg::addr_t load_addr,
	input fft_pkg::sample_t load_real,
	input fft_pkg::sample_t load_imag,
	input fft_pkg::addr_t rd_addr,
	output logic busy,
	output logic done,
	output fft_pkg::sample_t rd_real,
	output fft_pkg::sample_t rd_imag
);

	// pair stream from the sequencer
	logic issue;
	logic issue_last;
	fft_pkg::addr_t rd_even_addr, rd_odd_addr;
	fft_pkg::addr_t issue_even_addr, issue_odd_addr;
	fft_pkg::pair_t tw_index;

	// source samples into the butterfly
	fft_pkg::sample_t even_real, even_imag, odd_real, odd_imag;

	// results back to the buffer
	logic res_valid;
	logic res_last;
	fft_pkg::addr_t res_even_addr, res_odd_addr;
	fft_pkg::sample_t res_even_real, res_even_imag, res_odd_real, res_odd_imag;

	pair_sequencer u_seq
	(
		.clk(clk), .reset(reset), .start(start), .level(level), .done(done),
		.busy(busy), .issue(issue), .rd_even_addr(rd_even_addr),
		.rd_odd_addr(rd_odd_addr), .tw_index(tw_index),
		.issue_even_addr(issue_even_addr), .issue_odd_addr(issue_odd_addr),
		.issue_last(issue_last)
	);

	sample_buffer u_buf
	(
		.clk(clk), .reset(reset), .issue(issue),
		.rd_even_addr(rd_even_addr), .rd_odd_addr(rd_odd_addr),
		.res_valid(res_valid), .res_last(res_last),
		.res_even_addr(res_even_addr), .res_odd_addr(res_odd_addr),
		.res_even_real(res_even_real), .res_even_imag(res_even_imag),
		.res_odd_real(res_odd_real), .res_odd_imag(res_odd_imag),
		.load_en(load_en), .load_addr(load_addr),
		.load_real(load_real), .load_imag(load_imag), .rd_addr(rd_addr),
		.even_real(even_real), .even_imag(even_imag),
		.odd_real(odd_real), .odd_imag(odd_imag),
		.rd_real(rd_real), .rd_imag(rd_imag), .done(done)
	);

	butterfly u_bfly
	(
		.clk(clk), .reset(reset), .issue(issue), .tw_index(tw_index),
		.issue_even_addr(issue_even_addr), .issue_odd_addr(issue_odd_addr),
		.issue_last(issue_last),
		.even_real(even_real), .even_imag(even_imag),
		.odd_real(odd_real), .odd_imag(odd_imag),
		.res_valid(res_valid), .res_last(res_last),
		.res_even_addr(res_even_addr), .res_odd_addr(res_odd_addr),
		.res_even_real(res_even_real), .res_even_imag(res_even_imag),
		.res_odd_real(res_odd_real), .res_odd_imag(res_odd_imag)
	);

endmodule

// ==== tb_fft_stage.sv ====
`timescale 1ns/1ps

module tb_fft_stage;

	localparam int N = fft_pkg::N_POINTS;
	// a stage test loads, runs and reads back in about 50 cycles and all tests need about 450
	localparam int EST_CYCLES = 500;
	localparam int CYCLE_LIMIT = 4 * EST_CYCLES;
	localparam int STAGE_LIMIT = 40;
	localparam int DONE_LATENCY = N / 2 + 4;

	logic clk;
	logic reset;
	logic start;
	fft_pkg::level_t level;
	logic load_en;
	fft_pkg::addr_t load_addr;
	fft_pkg::sample_t load_real, load_imag;
	fft_pkg::addr_t rd_addr;
	logic busy;
	logic done;
	fft_pkg::sample_t rd_real, rd_imag;

	// expected contents of the source bank
	fft_pkg::sample_t model_real [0:N-1];
	fft_pkg::sample_t model_imag [0:N-1];
	logic [31:0] tw_table [0:N/2-1];

	logic [31:0] rng_state;
	int cycle_count = 0;
	int error_count = 0;
	int check_count = 0;
	int test_count = 0;

	fft_stage_top DUT
	(
		.clk(clk), .reset(reset), .start(start), .level(level),
		.load_en(load_en), .load_addr(load_addr), .load_real(load_real),
		.load_imag(load_imag), .rd_addr(rd_addr),
		.busy(busy), .done(done), .rd_real(rd_real), .rd_imag(rd_imag)
	);

	always #4 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// uniform from -2048 to 2047
	function automatic int random_sample();
		rng_state = lcg_next(rng_state);
		return int'(rng_state[27:16]) - 2048;
	endfunction

	task automatic check_value(input string what, input logic signed [31:0] got,
		input logic signed [31:0] expected);
		check_count++;
		if (got !== expected)
		begin
			error_count++;
			$display("Mismatch at %0t: %s got %0d, expected %0d", $time, what, got, expected);
		end
	endtask

	task automatic fill_random();
		for (int i = 0; i < N; i++)
		begin
			model_real[i] = fft_pkg::sample_t'(random_sample());
			model_imag[i] = fft_pkg::sample_t'(random_sample());
		end
	endtask

	task automatic load_all();
		for (int i = 0; i < N; i++)
		begin
			@(posedge clk);
			load_en <= 1'b1;
			load_addr <= fft_pkg::addr_t'(i);
			load_real <= model_real[i];
			load_imag <= model_imag[i];
		end
		@(posedge clk);
		load_en <= 1'b0;
	endtask

	// addresses go out back to back, so each word must show up one cycle later
	task automatic read_all(input string tag);
		for (int i = 0; i <= N; i++)
		begin
			@(posedge clk);
			if (i < N)
			begin
				rd_addr <= fft_pkg::addr_t'(i);
			end
			@(negedge clk);
			if (i > 0)
			begin
				check_value($sformatf("%s real[%0d]", tag, i - 1), rd_real, model_real[i - 1]);
				check_value($sformatf("%s imag[%0d]", tag, i - 1), rd_imag, model_imag[i - 1]);
			end
		end
	endtask

	// one radix-2 stage on the model arrays
	task automatic model_stage(input int lvl);
		int mask;
		int span;
		int k;
		int ea;
		int oa;
		longint tr, ti, xr, xi, prod_r, prod_i;
		fft_pkg::sample_t next_real [0:N-1];
		fft_pkg::sample_t next_imag [0:N-1];
		mask = 7 >> lvl;
		span = (N / 2) >> lvl;
		for (int p = 0; p < N / 2; p++)
		begin
			k = p & ~mask & 7;
			ea = (p & mask) | (k << 1);
			oa = ea + span;
			tr = longint'($signed(tw_table[k][31:16]));
			ti = longint'($signed(tw_table[k][15:0]));
			xr = longint'(model_real[oa]);
			xi = longint'(model_imag[oa]);
			prod_r = (xr * tr - xi * ti) >>> fft_pkg::TW_FRAC;
			prod_i = (xr * ti + xi * tr) >>> fft_pkg::TW_FRAC;
			next_real[ea] = fft_pkg::sample_t'(longint'(model_real[ea]) + prod_r);
			next_imag[ea] = fft_pkg::sample_t'(longint'(model_imag[ea]) + prod_i);
			next_real[oa] = fft_pkg::sample_t'(longint'(model_real[ea]) - prod_r);
			next_imag[oa] = fft_pkg::sample_t'(longint'(model_imag[ea]) - prod_i);
		end
		model_real = next_real;
		model_imag = next_imag;
	endtask

	// restart_cycle above zero sends a stray start with another level during the run
	task automatic run_stage(input int lvl, input int restart_cycle);
		int cycles;
		bit seen;
		bit busy_held;
		@(posedge clk);
		start <= 1'b1;
		level <= fft_pkg::level_t'(lvl);
		@(posedge clk);
		start <= 1'b0;
		cycles = 0;
		seen = 1'b0;
		busy_held = 1'b1;
		while (!seen && cycles < STAGE_LIMIT)
		begin
			@(negedge clk);
			cycles++;
			busy_held = busy_held & (busy === 1'b1);
			seen = (done === 1'b1);
			@(posedge clk);
			start <= (cycles == restart_cycle);
			level <= fft_pkg::level_t'((cycles == restart_cycle) ? 3 - lvl : lvl);
		end
		if (!seen)
		begin
			error_count++;
			$display("done never came within %0d cycles of start at level %0d", STAGE_LIMIT, lvl);
		end
		else
		begin
			check_value("cycles from start to done", cycles, DONE_LATENCY);
			check_value("busy held through done", busy_held, 1);
			@(negedge clk);
			check_value("busy after done", busy, 0);
			check_value("done after its pulse", done, 0);
		end
		model_stage(lvl);
	endtask

	task automatic finish_test(input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before)
		begin
			$display("test %0d %s: ok", test_count, name);
		end
		else
		begin
			$display("test %0d %s: %0d errors", test_count, name, error_count - errors_before);
		end
	endtask

	initial
	begin
		int errs;
		clk = 1'b0;
		rng_state = 32'h3b11;
		$readmemh("twiddle.hex", tw_table);
		reset <= 1'b1;
		start <= 1'b0;
		level <= '0;
		load_en <= 1'b0;
		load_addr <= '0;
		load_real <= '0;
		load_imag <= '0;
		rd_addr <= '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		errs = error_count;
		@(negedge clk);
		check_value("busy after reset", busy, 0);
		check_value("done after reset", done, 0);
		fill_random();
		load_all();
		read_all("loaded");
		finish_test("reset state and load read back", errs);

		errs = error_count;
		fill_random();
		load_all();
		run_stage(0, 0);
		read_all("level 0");
		finish_test("level 0 stage", errs);

		errs = error_count;
		for (int lvl = 1; lvl < 4; lvl++)
		begin
			fill_random();
			load_all();
			run_stage(lvl, 0);
			read_all($sformatf("level %0d", lvl));
		end
		finish_test("levels 1 to 3", errs);

		errs = error_count;
		fill_random();
		load_all();
		for (int lvl = 0; lvl < 4; lvl++)
		begin
			run_stage(lvl, 0);
			read_all($sformatf("chained level %0d", lvl));
		end
		finish_test("four chained stages", errs);

		errs = error_count;
		fill_random();
		load_all();
		run_stage(2, 5);
		read_all("restart level 2");
		finish_test("done timing and ignored start", errs);

		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
		if (error_count == 0)
		begin
			$display("*** TEST PASSED ***");
		end
		else
		begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== twiddle.hex ====
// twiddle k = exp(-j*2*pi*k/16) for k = 0 to 7, one word per k
// upper half is the real part, lower half the imaginary part, both Q2.14
40000000
3B21E782
2D41D2BF
187EC4DF
0000C000
E782C4DF
D2BFD2BF
C4DFE782

// ==== src.f ====
fft_pkg.sv
pair_sequencer.sv
sample_buffer.sv
butterfly.sv
fft_stage_top.sv
tb_fft_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it into sim.log and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module tb_fft_stage -f src.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_fft_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF '*** TEST PASSED ***' sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
